// File: dv/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;

    localparam int clk_period   = 40;
    localparam int n_requests   = 240;
    // accept, lookup, fetch of up to 7 cycles, refill, lookup, gap
    localparam int worst_cycles = 16;

    logic                  clk;
    logic                  rst_n;
    logic                  cpu_read;
    logic                  cpu_write;
    logic                  mem_cancel;
    logic                  pmem_resp;
    logic                  resp_soon;
    logic                  cache_resp;
    logic                  hit;
    logic                  miss;
    logic [31:0]           cpu_rdata;
    icache_pkg::cpu_addr_t cpu_addr;
    icache_pkg::line_t     pmem_rdata;
    icache_pkg::mem_req_t  mem_req;
    icache_pkg::mem_req_t  last_req;
    logic                  hold_req = 1'b0;
    logic [3:0]            flags;

    // reference model of the tag ways and plru bits
    logic [23:0] m_tag [2][16];
    logic        m_valid [2][16];
    logic        m_plru [16];

    icache_top u_dut (.*);
    tb_icache_mem u_mem (.*);

    // resp, hit, miss, read
    assign flags = {cache_resp, hit, miss, mem_req.read};

    task automatic expect_eq(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
        assert (act === exp) else begin
            $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h3c5a_96e1;
    endfunction

    task automatic predict(input icache_pkg::cpu_addr_t ra, output logic exp_hit,
                           output logic way);
        exp_hit = 1'b1;
        if (m_valid[0][ra.index] && m_tag[0][ra.index] == ra.tag) begin
            way = 1'b0;
        end else if (m_valid[1][ra.index] && m_tag[1][ra.index] == ra.tag) begin
            way = 1'b1;
        end else begin
            exp_hit = 1'b0;
            // empty way first, then the plru choice
            if (!m_valid[0][ra.index]) way = 1'b0;
            else if (!m_valid[1][ra.index]) way = 1'b1;
            else way = m_plru[ra.index];
        end
    endtask

    // cancel_in 0 none, 1 in lookup, 2 in fetch; want -1 any, 0 miss, 1 hit
    task automatic access(input logic [31:0] a, input int cancel_in, input int want);
        icache_pkg::cpu_addr_t ra;
        logic                  exp_hit;
        logic                  way;
        ra = a;
        predict(ra, exp_hit, way);
        if (want >= 0) expect_eq("predicted hit", 64'(want), 64'(exp_hit));
        cpu_read <= 1'b1;
        cpu_addr <= ra;
        @(posedge clk);
        if (cancel_in == 1) mem_cancel <= 1'b1;
        @(posedge clk);
        if (cancel_in == 1) begin
            expect_eq("resp/hit/miss/read", 64'(4'b1000), 64'(flags));
        end else if (exp_hit) begin
            expect_eq("resp/hit/miss/read", 64'(4'b1100), 64'(flags));
            expect_eq("cpu_rdata", 64'(word_at(a)), 64'(cpu_rdata));
            m_plru[ra.index] = !way;
        end else begin
            expect_eq("resp/hit/miss/read", 64'(4'b0010), 64'(flags));
            @(posedge clk);
            expect_eq("resp/hit/miss/read", 64'(4'b0001), 64'(flags));
            expect_eq("mem_req", 64'({1'b1, a[31:4], 4'h0}), 64'(mem_req));
            if (cancel_in == 2) begin
                // line lands in the cancel cycle and must be dropped
                while (!resp_soon) @(posedge clk);
                mem_cancel <= 1'b1;
                @(posedge clk);
                expect_eq("pmem_resp/resp/hit/miss/read", 64'(5'b11001),
                          64'({pmem_resp, flags}));
            end else begin
                while (!pmem_resp) @(posedge clk);
                m_valid[way][ra.index] = 1'b1;
                m_tag[way][ra.index]   = ra.tag;
                m_plru[ra.index]       = !way;
                @(posedge clk);
                expect_eq("resp/hit/miss/read", 64'(4'b1100), 64'(flags));
                expect_eq("cpu_rdata", 64'(word_at(a)), 64'(cpu_rdata));
            end
        end
        cpu_read   <= 1'b0;
        mem_cancel <= 1'b0;
        @(posedge clk);
        expect_eq("busy", 64'd0, 64'(u_dut.busy));
        expect_eq("resp/hit/miss/read", 64'd0, 64'(flags));
    endtask

    // a pending fetch must keep its request still
    always @(posedge clk) begin
        if (hold_req) expect_eq("mem_req", 64'(last_req), 64'(mem_req));
        hold_req <= rst_n && mem_req.read && !pmem_resp && !mem_cancel;
        last_req <= mem_req;
    end

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(clk_period * (n_requests * worst_cycles + 200));
        $display("timeout: the cache stopped answering requests");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        icache_pkg::cpu_addr_t ra;
        void'($urandom(32'h5d21));
        rst_n      = 1'b0;
        cpu_read   = 1'b0;
        cpu_write  = 1'b0;
        cpu_addr   = '0;
        mem_cancel = 1'b0;
        for (int s = 0; s < 16; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_plru[s]     = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        expect_eq("resp/hit/miss/read", 64'd0, 64'(flags));

        // cancel while idle answers at once
        mem_cancel <= 1'b1;
        @(posedge clk);
        expect_eq("resp/hit/miss/read", 64'(4'b1000), 64'(flags));
        mem_cancel <= 1'b0;
        @(posedge clk);
        expect_eq("busy", 64'd0, 64'(u_dut.busy));

        // fill one line, then hit each of its words
        access(32'h0000_1230, 0, 0);
        for (int w = 0; w < 4; w++) begin
            access(32'h0000_1230 + 32'(4 * w), 0, 1);
        end

        // three tags in set 5
        access(32'h0000_a050, 0, 0);
        access(32'h0000_b054, 0, 0);
        access(32'h0000_a058, 0, 1);
        access(32'h0000_c05c, 0, 0);
        access(32'h0000_a050, 0, 1);
        access(32'h0000_b050, 0, 0);

        access(32'h0000_a050, 1, 1);
        access(32'h0000_a054, 0, 1);
        access(32'h0000_d070, 2, 0);
        access(32'h0000_d070, 0, 0);

        // read with write high is never taken
        cpu_read  <= 1'b1;
        cpu_write <= 1'b1;
        cpu_addr  <= 32'h0000_1230;
        repeat (11) begin
            @(posedge clk);
            expect_eq("accept/resp/hit/miss/read", 64'd0, 64'({u_dut.accept, flags}));
        end
        cpu_read  <= 1'b0;
        cpu_write <= 1'b0;
        @(posedge clk);

        // small pool so sets conflict often
        for (int n = 0; n < 200; n++) begin
            ra.tag      = 24'($urandom_range(3, 0));
            ra.index    = 4'($urandom_range(3, 0));
            ra.word     = 2'($urandom_range(3, 0));
            ra.byte_sel = 2'b00;
            access(ra, 0, -1);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: dv/tb_icache_mem.sv
`timescale 1ns/1ps

module tb_icache_mem (
    input  logic                 clk,
    input  logic                 rst_n,
    input  icache_pkg::mem_req_t mem_req,
    output logic                 pmem_resp,
    output icache_pkg::line_t    pmem_rdata,
    output logic                 resp_soon
);

    int unsigned       count = 0;
    logic              resp_q = 1'b0;
    icache_pkg::line_t rdata_q = '0;

    // high in the cycle before the line comes back
    assign resp_soon  = (count == 1);
    assign pmem_resp  = resp_q;
    assign pmem_rdata = rdata_q;

    always @(posedge clk) begin
        resp_q <= 1'b0;
        if (!rst_n || !mem_req.read || resp_q) begin
            count <= 0;
        end else if (count == 0) begin
            count <= $urandom_range(6, 1);
        end else if (count == 1) begin
            count  <= 0;
            resp_q <= 1'b1;
            // word k holds its own byte address xor a fixed key
            for (int k = 0; k < 4; k++) begin
                rdata_q[k] <= {mem_req.addr[31:4], 2'(k), 2'b00} ^ 32'h3c5a_96e1;
            end
        end else begin
            count <= count - 1;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_icache
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_icache 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "TB PASSED"; then
    exit 0
fi
echo "no pass message in the simulation output"
exit 1

// File: sim.f
+incdir+source
source/icache_pkg.sv
source/icache_req_latch.sv
source/icache_control.sv
source/icache_way_ram.sv
source/icache_store.sv
source/icache_fill.sv
source/icache_top.sv
dv/tb_icache_mem.sv
dv/tb_icache.sv

// File: source/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// address and data widths
`define ICACHE_ADDR_W 32
`define ICACHE_WORD_W 32

// line and set geometry
`define ICACHE_WORDS 4
`define ICACHE_SETS 16

// address split as tag | index | word | byte
`define ICACHE_INDEX_W 4
`define ICACHE_OFFSET_W 4
`define ICACHE_TAG_W 24

`endif

// File: source/icache_control.sv
`timescale 1ns/1ps

module icache_control (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                accept,
    input  logic                mem_cancel,
    input  icache_pkg::lookup_t lookup,
    input  logic                pmem_resp,
    output logic                busy,
    output icache_pkg::ctrl_t   ctrl,
    output logic                cache_resp,
    output logic                hit,
    output logic                miss
);

    icache_pkg::state_t state;
    icache_pkg::state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= icache_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    assign busy = (state != icache_pkg::idle);

    // defaults first, then per-state overrides
    always_comb begin
        state_next = state;
        ctrl       = '0;
        cache_resp = 1'b0;
        hit        = 1'b0;
        miss       = 1'b0;

        if (mem_cancel) begin
            // cancel wins over everything, line in flight is dropped
            cache_resp = 1'b1;
            state_next = icache_pkg::idle;
        end else begin
            case (state)
                icache_pkg::idle: begin
                    if (accept) begin
                        state_next = icache_pkg::hit_look;
                    end
                end
                icache_pkg::hit_look: begin
                    ctrl.lookup_en = 1'b1;
                    if (lookup.hit) begin
                        ctrl.plru_update = 1'b1;
                        cache_resp       = 1'b1;
                        hit              = 1'b1;
                        state_next       = icache_pkg::idle;
                    end else begin
                        // fill side latches victim and raises read next edge
                        ctrl.victim_pick = 1'b1;
                        miss             = 1'b1;
                        state_next       = icache_pkg::allocate;
                    end
                end
                icache_pkg::allocate: begin
                    if (pmem_resp) begin
                        ctrl.fill_write = 1'b1;
                        state_next      = icache_pkg::hit_look;
                    end
                end
                default: begin
                    state_next = icache_pkg::idle;
                end
            endcase
        end
    end

endmodule

// File: source/icache_fill.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_fill (
    input  logic                  clk,
    input  logic                  rst_n,
    input  icache_pkg::cpu_addr_t req_addr,
    input  icache_pkg::ctrl_t     ctrl,
    input  logic                  plru_way,
    input  logic                  pmem_resp,
    input  logic                  mem_cancel,
    output logic                  victim_way,
    output icache_pkg::mem_req_t  mem_req
);

    logic                      read_q;
    logic [`ICACHE_ADDR_W-1:0] addr_q;

    // victim and read level stay put until the line lands or is cancelled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_q     <= 1'b0;
            victim_way <= 1'b0;
        end else if (mem_cancel) begin
            read_q <= 1'b0;
        end else if (ctrl.victim_pick) begin
            read_q     <= 1'b1;
            victim_way <= plru_way;
        end else if (pmem_resp) begin
            read_q <= 1'b0;
        end
    end

    // line-aligned fetch address
    always_ff @(posedge clk) begin
        if (ctrl.victim_pick) begin
            addr_q <= {req_addr.tag, req_addr.index, {`ICACHE_OFFSET_W{1'b0}}};
        end
    end

    assign mem_req.read = read_q;
    assign mem_req.addr = addr_q;

endmodule

// File: source/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]                           tag;
        logic [`ICACHE_INDEX_W-1:0]                         index;
        logic [$clog2(`ICACHE_WORDS)-1:0]                   word;
        logic [`ICACHE_OFFSET_W-$clog2(`ICACHE_WORDS)-1:0]  byte_sel;
    } cpu_addr_t;

    typedef struct packed {
        logic                     valid;
        logic [`ICACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef logic [`ICACHE_WORDS-1:0][`ICACHE_WORD_W-1:0] line_t;

    typedef struct packed {
        logic                      hit;
        logic                      way;
        logic [`ICACHE_WORD_W-1:0] word;
    } lookup_t;

    // controller strobes to store and fill
    typedef struct packed {
        logic lookup_en;
        logic plru_update;
        logic fill_write;
        logic victim_pick;
    } ctrl_t;

    typedef struct packed {
        logic                      read;
        logic [`ICACHE_ADDR_W-1:0] addr;
    } mem_req_t;

    typedef enum logic [1:0] {
        idle     = 2'd0,
        hit_look = 2'd1,
        allocate = 2'd2
    } state_t;

endpackage

// File: source/icache_req_latch.sv
`timescale 1ns/1ps

module icache_req_latch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cpu_read,
    input  logic                  cpu_write,
    input  icache_pkg::cpu_addr_t cpu_addr,
    input  logic                  busy,
    output logic                  accept,
    output icache_pkg::cpu_addr_t req_addr
);

    icache_pkg::cpu_addr_t addr_q;

    // only plain reads are taken, and only while the controller is free
    assign accept = cpu_read && !cpu_write && !busy;

    // address held from accept until the next accept
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (accept) begin
            addr_q <= cpu_addr;
        end
    end

    assign req_addr = addr_q;

endmodule

// File: source/icache_store.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_store (
    input  logic                  clk,
    input  logic                  rst_n,
    input  icache_pkg::cpu_addr_t req_addr,
    input  icache_pkg::ctrl_t     ctrl,
    input  logic                  victim_way,
    input  icache_pkg::line_t     fill_line,
    output icache_pkg::lookup_t   lookup,
    output logic                  plru_way
);

    icache_pkg::tag_entry_t tag_rd [2];
    icache_pkg::line_t      line_rd [2];
    icache_pkg::tag_entry_t tag_wr;
    logic [1:0]             way_we;
    logic [1:0]             way_match;
    logic [`ICACHE_SETS-1:0] plru_q;

    assign tag_wr = '{valid: 1'b1, tag: req_addr.tag};

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign way_we[w] = ctrl.fill_write && (victim_way == w[0]);

        icache_way_ram #(.entry_t(icache_pkg::tag_entry_t)) u_tag (
            .clk(clk), .rst_n(rst_n), .we(way_we[w]),
            .waddr(req_addr.index), .wdata(tag_wr),
            .raddr(req_addr.index), .rdata(tag_rd[w])
        );

        icache_way_ram #(.entry_t(icache_pkg::line_t)) u_data (
            .clk(clk), .rst_n(rst_n), .we(way_we[w]),
            .waddr(req_addr.index), .wdata(fill_line),
            .raddr(req_addr.index), .rdata(line_rd[w])
        );

        assign way_match[w] = tag_rd[w].valid && (tag_rd[w].tag == req_addr.tag);
    end

    // way 1 only wins when way 0 misses
    assign lookup.hit  = ctrl.lookup_en && (|way_match);
    assign lookup.way  = !way_match[0];
    assign lookup.word = line_rd[lookup.way][req_addr.word];

    // bit names the way to replace next
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            plru_q <= '0;
        end else if (ctrl.plru_update) begin
            plru_q[req_addr.index] <= !lookup.way;
        end
    end

    // an empty way is always filled before evicting
    always_comb begin
        if (!tag_rd[0].valid) begin
            plru_way = 1'b0;
        end else if (!tag_rd[1].valid) begin
            plru_way = 1'b1;
        end else begin
            plru_way = plru_q[req_addr.index];
        end
    end

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cpu_read,
    input  logic                      cpu_write,
    input  icache_pkg::cpu_addr_t     cpu_addr,
    input  logic                      mem_cancel,
    input  logic                      pmem_resp,
    input  icache_pkg::line_t         pmem_rdata,
    output logic                      cache_resp,
    output logic [`ICACHE_WORD_W-1:0] cpu_rdata,
    output icache_pkg::mem_req_t      mem_req,
    output logic                      hit,
    output logic                      miss
);

    icache_pkg::cpu_addr_t req_addr;
    icache_pkg::ctrl_t     ctrl;
    icache_pkg::lookup_t   lookup;
    logic                  accept;
    logic                  busy;
    logic                  plru_way;
    logic                  victim_way;

    icache_req_latch u_req_latch (
        .clk(clk), .rst_n(rst_n), .cpu_read(cpu_read), .cpu_write(cpu_write),
        .cpu_addr(cpu_addr), .busy(busy), .accept(accept), .req_addr(req_addr)
    );

    icache_control u_control (
        .clk(clk), .rst_n(rst_n), .accept(accept), .mem_cancel(mem_cancel),
        .lookup(lookup), .pmem_resp(pmem_resp), .busy(busy), .ctrl(ctrl),
        .cache_resp(cache_resp), .hit(hit), .miss(miss)
    );

    icache_store u_store (
        .clk(clk), .rst_n(rst_n), .req_addr(req_addr), .ctrl(ctrl),
        .victim_way(victim_way), .fill_line(pmem_rdata), .lookup(lookup),
        .plru_way(plru_way)
    );

    icache_fill u_fill (
        .clk(clk), .rst_n(rst_n), .req_addr(req_addr), .ctrl(ctrl),
        .plru_way(plru_way), .pmem_resp(pmem_resp), .mem_cancel(mem_cancel),
        .victim_way(victim_way), .mem_req(mem_req)
    );

    assign cpu_rdata = lookup.word;

endmodule

// File: source/icache_way_ram.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_way_ram #(
    parameter type entry_t = logic
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       we,
    input  logic [`ICACHE_INDEX_W-1:0] waddr,
    input  entry_t                     wdata,
    input  logic [`ICACHE_INDEX_W-1:0] raddr,
    output entry_t                     rdata
);

    entry_t mem [`ICACHE_SETS];

    // reset wipes every entry, so tag ways come up invalid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `ICACHE_SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // async read for a same-cycle lookup
    assign rdata = mem[raddr];

endmodule
